//--- common/frontend_settings.svh
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

//////////////////////////////
// Front end sizing
//////////////////////////////

// Pair rows per buffer bank, also the fetch credit budget
`define IBUF_DEPTH 8

// Bundles the decoder can hold
`define DEC_CREDITS 4

// First fetch address out of reset
`define RESET_PC 32'h0000_0100

`endif

//--- common/fetch_pkg.sv
package fetch_pkg;

    // Request to instruction memory, pc is pair aligned
    // Also used for predictor redirects, where pc may point at slot 1
    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fetch_req_t;

    // Memory answer, one cycle after the request
    typedef struct packed {
        logic [1:0][31:0] inst;
        logic             fault;
    } fetch_rsp_t;

    // Pair after predecode
    typedef struct packed {
        logic             valid;
        logic [31:0]      pc;
        logic [1:0][31:0] inst;
        logic [1:0]       slot_valid;
        logic             fault;
        logic [1:0]       taken;
        logic [31:0]      target;
    } pred_pair_t;

    // Packet handed to the decoder
    typedef struct packed {
        logic             valid;
        logic [31:0]      pc;
        logic [1:0][31:0] inst;
        logic [1:0]       slot_valid;
        logic             fault;
        logic [1:0]       taken;
        logic [31:0]      target;
    } inst_bundle_t;

endpackage

//--- common/isa_pkg.sv
package isa_pkg;

    // Conditional branch major opcode
    localparam logic [5:0] BR_OPCODE = 6'b000100;

    //////////////////////////////
    // Instruction word views
    //////////////////////////////

    // Branch layout, offset counts words
    typedef struct packed {
        logic [5:0]         opcode;
        logic [4:0]         rs;
        logic [4:0]         rt;
        logic signed [15:0] offset;
    } br_fields_t;

    typedef union packed {
        logic [31:0] raw;
        br_fields_t  br;
    } inst_word_u;

endpackage

//--- rtl/pc_gen.sv
`timescale 1ns/1ps
`include "frontend_settings.svh"

module pc_gen (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  redirect_valid_i,
    input  logic [31:0]           redirect_pc_i,
    input  fetch_pkg::fetch_req_t pred_redirect_i,
    input  logic                  fetch_credit_i,
    input  logic                  cancel_credit_i,
    output fetch_pkg::fetch_req_t imem_req_o
);

    localparam int CREDIT_W = $clog2(`IBUF_DEPTH + 1);

    logic [31:0]         pc_q;
    logic [CREDIT_W-1:0] credits_q;
    logic                issue;

    // No fetch in reset or a redirect cycle, the sequential pc there is stale
    assign issue = !rst && (credits_q != '0) && !redirect_valid_i && !pred_redirect_i.valid;

    assign imem_req_o.valid = issue;
    assign imem_req_o.pc    = pc_q;

    //////////////////////////////
    // Next fetch address
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= `RESET_PC & ~32'd7;
        end else if (redirect_valid_i) begin
            pc_q <= {redirect_pc_i[31:3], 3'b000};
        end else if (pred_redirect_i.valid) begin
            // Odd word target, fetch its pair base
            pc_q <= {pred_redirect_i.pc[31:3], 3'b000};
        end else if (issue) begin
            pc_q <= pc_q + 32'd8;
        end
    end

    //////////////////////////////
    // Fetch credits
    //////////////////////////////

    // Up to two returns per cycle, one spend per request
    always_ff @(posedge clk) begin
        if (rst || redirect_valid_i) begin
            credits_q <= CREDIT_W'(`IBUF_DEPTH);
        end else begin
            credits_q <= credits_q + CREDIT_W'(fetch_credit_i)
                       + CREDIT_W'(cancel_credit_i) - CREDIT_W'(issue);
        end
    end

endmodule

//--- rtl/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  flush_i,
    input  fetch_pkg::fetch_req_t req_i,
    input  fetch_pkg::fetch_rsp_t rsp_i,
    output fetch_pkg::pred_pair_t pair_o,
    output fetch_pkg::fetch_req_t pred_redirect_o,
    output logic                  cancel_credit_o
);

    import fetch_pkg::*;
    import isa_pkg::*;

    logic             req_valid_q;
    logic [31:0]      req_pc_q;
    logic             pair_valid_q;
    logic [31:0]      pair_pc_q;
    fetch_rsp_t       pair_rsp_q;
    logic             cancel_q;
    logic             entry_hi_q;
    inst_word_u [1:0] word;
    logic [1:0]       bwd_branch;
    logic [1:0]       slot_valid;
    logic [1:0]       taken;
    logic             live;
    logic [31:0]      br_pc;
    logic [31:0]      br_disp;
    logic [31:0]      target;

    // Control state, all of it dies on a backend flush
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            req_valid_q  <= 1'b0;
            pair_valid_q <= 1'b0;
            cancel_q     <= 1'b0;
            entry_hi_q   <= 1'b0;
        end else begin
            req_valid_q  <= req_i.valid;
            pair_valid_q <= req_valid_q;
            // The pair right behind a taken branch is wrong path
            cancel_q     <= pred_redirect_o.valid;
            if (pred_redirect_o.valid) begin
                entry_hi_q <= target[2];
            end else if (live) begin
                entry_hi_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        req_pc_q   <= req_i.pc;
        pair_pc_q  <= req_pc_q;
        pair_rsp_q <= rsp_i;
    end

    //////////////////////////////
    // Static BTFN prediction
    //////////////////////////////

    always_comb begin
        for (int i = 0; i < 2; i++) begin
            word[i].raw   = pair_rsp_q.inst[i];
            bwd_branch[i] = (word[i].br.opcode == BR_OPCODE) && (word[i].br.offset < 16'sd0);
        end
        live          = pair_valid_q && !cancel_q;
        // Entry at slot 1 of a target pair skips slot 0
        slot_valid[0] = !entry_hi_q;
        taken[0]      = slot_valid[0] && bwd_branch[0];
        slot_valid[1] = !taken[0];
        taken[1]      = slot_valid[1] && bwd_branch[1];
        br_pc         = taken[0] ? pair_pc_q : pair_pc_q + 32'd4;
        br_disp       = taken[0] ? {{14{word[0].br.offset[15]}}, word[0].br.offset, 2'b00}
                                 : {{14{word[1].br.offset[15]}}, word[1].br.offset, 2'b00};
        target        = br_pc + br_disp;
    end

    always_comb begin
        pair_o.valid      = live;
        pair_o.pc         = pair_pc_q;
        pair_o.inst[0]    = word[0].raw;
        pair_o.inst[1]    = word[1].raw;
        pair_o.slot_valid = slot_valid;
        pair_o.fault      = pair_rsp_q.fault;
        pair_o.taken      = taken;
        pair_o.target     = target;
    end

    assign pred_redirect_o.valid = live && (taken != 2'b00);
    assign pred_redirect_o.pc    = target;
    assign cancel_credit_o       = pair_valid_q && cancel_q;

endmodule

//--- inst_buffer/fifo_bank.sv
`timescale 1ns/1ps

module fifo_bank #(
    parameter int DEPTH = 8,
    parameter int WIDTH = 32
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             flush_i,
    input  logic             push_i,
    input  logic [WIDTH-1:0] push_data_i,
    input  logic             pop_i,
    output logic [WIDTH-1:0] pop_data_o,
    output logic             empty_o
);

    localparam int AW = $clog2(DEPTH);

    logic [WIDTH-1:0] mem [DEPTH];
    logic [AW-1:0]    wr_ptr_q;
    logic [AW-1:0]    rd_ptr_q;
    logic [AW:0]      count_q;

    // Storage
    always_ff @(posedge clk) begin
        if (push_i) begin
            mem[wr_ptr_q] <= push_data_i;
        end
    end

    // Pointers and occupancy, flush empties in one cycle
    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop_i) begin
                rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            count_q <= count_q + (AW + 1)'(push_i) - (AW + 1)'(pop_i);
        end
    end

    assign pop_data_o = mem[rd_ptr_q];
    assign empty_o    = (count_q == '0);

endmodule

//--- inst_buffer/inst_buffer.sv
`timescale 1ns/1ps
`include "frontend_settings.svh"

module inst_buffer (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush_i,
    input  fetch_pkg::pred_pair_t   pair_i,
    input  logic                    dec_credit_i,
    output fetch_pkg::inst_bundle_t bundle_o,
    output logic                    fetch_credit_o
);

    import fetch_pkg::*;

    localparam int DEC_W = $clog2(`DEC_CREDITS + 1);

    // Slot 0 row carries the fields shared by the pair
    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        valid;
        logic        taken;
        logic        fault;
        logic [31:0] target;
    } slot0_row_t;

    typedef struct packed {
        logic [31:0] inst;
        logic        valid;
        logic        taken;
    } slot1_row_t;

    slot0_row_t       row0_in;
    slot0_row_t       row0_out;
    slot1_row_t       row1_in;
    slot1_row_t       row1_out;
    logic [1:0]       empty;
    logic             pop;
    logic [DEC_W-1:0] dec_credits_q;
    inst_bundle_t     bundle_d;
    inst_bundle_t     bundle_q;
    logic             bundle_valid_q;

    //////////////////////////////
    // Split pair into two rows
    //////////////////////////////

    always_comb begin
        row0_in.pc     = pair_i.pc;
        row0_in.inst   = pair_i.inst[0];
        row0_in.valid  = pair_i.slot_valid[0];
        row0_in.taken  = pair_i.taken[0];
        row0_in.fault  = pair_i.fault;
        row0_in.target = pair_i.target;
        row1_in.inst   = pair_i.inst[1];
        row1_in.valid  = pair_i.slot_valid[1];
        row1_in.taken  = pair_i.taken[1];
    end

    fifo_bank #(
        .DEPTH (`IBUF_DEPTH),
        .WIDTH ($bits(slot0_row_t))
    ) u_bank0 (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush_i),
        .push_i      (pair_i.valid),
        .push_data_i (row0_in),
        .pop_i       (pop),
        .pop_data_o  (row0_out),
        .empty_o     (empty[0])
    );

    fifo_bank #(
        .DEPTH (`IBUF_DEPTH),
        .WIDTH ($bits(slot1_row_t))
    ) u_bank1 (
        .clk         (clk),
        .rst         (rst),
        .flush_i     (flush_i),
        .push_i      (pair_i.valid),
        .push_data_i (row1_in),
        .pop_i       (pop),
        .pop_data_o  (row1_out),
        .empty_o     (empty[1])
    );

    //////////////////////////////
    // Pop and decode credits
    //////////////////////////////

    // Banks move in lockstep, pop only with a credit in hand
    assign pop            = (empty == 2'b00) && (dec_credits_q != '0) && !flush_i;
    assign fetch_credit_o = pop;

    // Decoder still owns its credits across a flush
    always_ff @(posedge clk) begin
        if (rst) begin
            dec_credits_q <= DEC_W'(`DEC_CREDITS);
        end else begin
            dec_credits_q <= dec_credits_q + DEC_W'(dec_credit_i) - DEC_W'(pop);
        end
    end

    always_comb begin
        bundle_d.valid         = 1'b1;
        bundle_d.pc            = row0_out.pc;
        bundle_d.inst[0]       = row0_out.inst;
        bundle_d.inst[1]       = row1_out.inst;
        bundle_d.slot_valid[0] = row0_out.valid;
        bundle_d.slot_valid[1] = row1_out.valid;
        bundle_d.fault         = row0_out.fault;
        bundle_d.taken[0]      = row0_out.taken;
        bundle_d.taken[1]      = row1_out.taken;
        bundle_d.target        = row0_out.target;
    end

    always_ff @(posedge clk) begin
        if (rst || flush_i) begin
            bundle_valid_q <= 1'b0;
        end else begin
            bundle_valid_q <= pop;
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            bundle_q <= bundle_d;
        end
    end

    always_comb begin
        bundle_o       = bundle_q;
        bundle_o.valid = bundle_valid_q;
    end

endmodule

//--- rtl/frontend_top.sv
`timescale 1ns/1ps

module frontend_top (
    input  logic                    clk,
    input  logic                    rst,
    input  fetch_pkg::fetch_rsp_t   imem_rsp_i,
    input  logic                    redirect_valid_i,
    input  logic [31:0]             redirect_pc_i,
    input  logic                    dec_credit_i,
    output fetch_pkg::fetch_req_t   imem_req_o,
    output fetch_pkg::inst_bundle_t bundle_o
);

    import fetch_pkg::*;

    fetch_req_t pred_redirect;
    pred_pair_t pair;
    logic       fetch_credit;
    logic       cancel_credit;

    //////////////////////////////
    // Fetch, predecode, buffer
    //////////////////////////////

    pc_gen u_pc_gen (
        .clk              (clk),
        .rst              (rst),
        .redirect_valid_i (redirect_valid_i),
        .redirect_pc_i    (redirect_pc_i),
        .pred_redirect_i  (pred_redirect),
        .fetch_credit_i   (fetch_credit),
        .cancel_credit_i  (cancel_credit),
        .imem_req_o       (imem_req_o)
    );

    // Backend redirect doubles as flush for both later stages
    branch_predictor u_branch_predictor (
        .clk             (clk),
        .rst             (rst),
        .flush_i         (redirect_valid_i),
        .req_i           (imem_req_o),
        .rsp_i           (imem_rsp_i),
        .pair_o          (pair),
        .pred_redirect_o (pred_redirect),
        .cancel_credit_o (cancel_credit)
    );

    inst_buffer u_inst_buffer (
        .clk            (clk),
        .rst            (rst),
        .flush_i        (redirect_valid_i),
        .pair_i         (pair),
        .dec_credit_i   (dec_credit_i),
        .bundle_o       (bundle_o),
        .fetch_credit_o (fetch_credit)
    );

endmodule

//--- dv/frontend_sva.sv
`timescale 1ns/1ps
`include "frontend_settings.svh"

module frontend_sva (
    input logic clk,
    input logic rst,
    input logic flush_i,
    input logic bundle_valid_i,
    input logic dec_held_i,
    input logic credits_in_range_i
);

    int fail_count = 0;

    // Bundle popped last cycle needs a decode credit held then
    bundle_needs_credit: assert property (@(posedge clk) disable iff (rst)
        bundle_valid_i |-> $past(dec_held_i))
        else begin
            $error("bundle presented without a decode credit");
            fail_count++;
        end

    fetch_credit_range: assert property (@(posedge clk) disable iff (rst)
        credits_in_range_i)
        else begin
            $error("fetch credit count above buffer depth");
            fail_count++;
        end

    // Flush kills the output register
    flush_clears_bundle: assert property (@(posedge clk) disable iff (rst)
        flush_i |=> !bundle_valid_i)
        else begin
            $error("bundle valid right after a flush");
            fail_count++;
        end

endmodule

//////////////////////////////
// Attach to the DUT
//////////////////////////////

bind inst_buffer frontend_sva u_buffer_sva (
    .clk                (clk),
    .rst                (rst),
    .flush_i            (flush_i),
    .bundle_valid_i     (bundle_o.valid),
    .dec_held_i         (dec_credits_q != '0),
    .credits_in_range_i (1'b1)
);

bind pc_gen frontend_sva u_fetch_sva (
    .clk                (clk),
    .rst                (rst),
    .flush_i            (1'b0),
    .bundle_valid_i     (1'b0),
    .dec_held_i         (1'b1),
    .credits_in_range_i (credits_q <= `IBUF_DEPTH)
);

//--- dv/frontend_checker.sv
`timescale 1ns/1ps
`include "frontend_settings.svh"

module frontend_checker #(
    parameter logic [31:0] FAULT_LO = 32'h0000_0128,
    parameter logic [31:0] FAULT_HI = 32'h0000_0138
) (
    input  logic                    clk,
    input  logic                    rst,
    input  fetch_pkg::fetch_req_t   req_i,
    input  fetch_pkg::fetch_rsp_t   rsp_i,
    input  logic                    redirect_valid_i,
    input  logic [31:0]             redirect_pc_i,
    input  logic                    dec_credit_i,
    input  fetch_pkg::inst_bundle_t bundle_i,
    output int                      errors_o
);

    import isa_pkg::*;

    // Mirror of fetched pairs, indexed by pair address
    logic [31:0] word0 [128];
    logic [31:0] word1 [128];
    logic        seen [128];
    logic        pend;
    logic [31:0] pend_pc;
    logic [31:0] exp_pc;
    logic        exp_hi;
    int          returned;
    int          bundles;

    initial errors_o = 0;

    function automatic logic is_backward(input logic [31:0] w);
        return (w[31:26] == BR_OPCODE) && w[15];
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            errors_o++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    //////////////////////////////
    // Static BTFN walk
    //////////////////////////////

    task automatic check_bundle();
        logic [6:0]  row;
        logic [1:0]  sv;
        logic [1:0]  tk;
        logic [31:0] br_word;
        logic [31:0] br_pc;
        logic [31:0] target;
        row     = exp_pc[9:3];
        sv[0]   = !exp_hi;
        tk[0]   = sv[0] && is_backward(word0[row]);
        sv[1]   = !tk[0];
        tk[1]   = sv[1] && is_backward(word1[row]);
        br_word = tk[0] ? word0[row] : word1[row];
        br_pc   = tk[0] ? exp_pc : exp_pc + 32'd4;
        target  = br_pc + {{14{br_word[15]}}, br_word[15:0], 2'b00};
        if (!seen[row]) begin
            errors_o++;
            $display("Bundle for pair %h arrived but that pair was never fetched", exp_pc);
        end
        compare("bundle_o.pc", exp_pc, bundle_i.pc);
        compare("bundle_o.inst[0]", word0[row], bundle_i.inst[0]);
        compare("bundle_o.inst[1]", word1[row], bundle_i.inst[1]);
        compare("bundle_o.slot_valid", 32'(sv), 32'(bundle_i.slot_valid));
        compare("bundle_o.taken", 32'(tk), 32'(bundle_i.taken));
        compare("bundle_o.fault", 32'(exp_pc >= FAULT_LO && exp_pc < FAULT_HI),
                32'(bundle_i.fault));
        if (tk != 2'b00) begin
            compare("bundle_o.target", target, bundle_i.target);
            exp_pc = {target[31:3], 3'b000};
            exp_hi = target[2];
        end else begin
            exp_pc = exp_pc + 32'd8;
            exp_hi = 1'b0;
        end
    endtask

    // Sample mid cycle where everything is settled
    always @(negedge clk) begin
        if (rst) begin
            if (req_i.valid) begin
                errors_o++;
                $display("At %0t a fetch request was issued while reset was asserted",
                         $time);
            end
            pend     = 1'b0;
            exp_pc   = `RESET_PC;
            exp_hi   = 1'b0;
            returned = 0;
            bundles  = 0;
            for (int i = 0; i < 128; i++) begin
                seen[i] = 1'b0;
            end
        end else begin
            if (pend) begin
                word0[pend_pc[9:3]] = rsp_i.inst[0];
                word1[pend_pc[9:3]] = rsp_i.inst[1];
                seen[pend_pc[9:3]]  = 1'b1;
            end
            pend    = req_i.valid;
            pend_pc = req_i.pc;
            if (bundle_i.valid) begin
                bundles++;
                if (bundles > returned + `DEC_CREDITS) begin
                    errors_o++;
                    $display("At %0t more bundles were delivered than decode credits allow",
                             $time);
                end
                check_bundle();
            end
            if (dec_credit_i) begin
                returned++;
            end
            // Older bundle above is still legal, then restart the walk
            if (redirect_valid_i) begin
                exp_pc = {redirect_pc_i[31:3], 3'b000};
                exp_hi = 1'b0;
            end
        end
    end

endmodule

//--- dv/frontend_tb.sv
`timescale 1ns/1ps

module frontend_tb;

    import fetch_pkg::*;
    import isa_pkg::*;

    localparam int          NUM_SCEN = 6;
    localparam logic [31:0] FAULT_LO = 32'h0000_0128;
    localparam logic [31:0] FAULT_HI = 32'h0000_0138;

    typedef struct packed {
        logic [1:0]  kind;
        logic [7:0]  prob;
        logic [7:0]  hold;
        logic [7:0]  redir_cycle;
        logic [31:0] redir_pc;
        logic [7:0]  count;
    } scenario_t;

    logic         clk;
    logic         rst;
    fetch_rsp_t   imem_rsp;
    logic         redirect_valid;
    logic [31:0]  redirect_pc;
    logic         dec_credit;
    fetch_req_t   imem_req;
    inst_bundle_t bundle;

    logic [31:0]  mem [256];
    scenario_t    scen [NUM_SCEN];
    fetch_req_t   req_q;
    logic [31:0]  seed;
    int           owed;
    int           got;
    int           checked;
    int           chk_errors;
    int           limit_cycles;

    frontend_top UUT (
        .clk              (clk),
        .rst              (rst),
        .imem_rsp_i       (imem_rsp),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .dec_credit_i     (dec_credit),
        .imem_req_o       (imem_req),
        .bundle_o         (bundle)
    );

    frontend_checker #(
        .FAULT_LO (FAULT_LO),
        .FAULT_HI (FAULT_HI)
    ) u_checker (
        .clk              (clk),
        .rst              (rst),
        .req_i            (imem_req),
        .rsp_i            (imem_rsp),
        .redirect_valid_i (redirect_valid),
        .redirect_pc_i    (redirect_pc),
        .dec_credit_i     (dec_credit),
        .bundle_i         (bundle),
        .errors_o         (chk_errors)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] branch_word(input logic [15:0] offset);
        return {BR_OPCODE, 5'd1, 5'd2, offset};
    endfunction

    //////////////////////////////
    // Memory programs
    //////////////////////////////

    task automatic load_program(input logic [1:0] kind);
        // Filler words carry their own address and are never branches
        for (int a = 0; a < 256; a++) begin
            mem[a] = 32'h2000_0000 | (a << 2);
        end
        if (kind == 2'd1) begin
            mem[32'h118 >> 2] = branch_word(-16'sd5);
            mem[32'h10C >> 2] = branch_word(16'sd1);
        end else if (kind == 2'd2) begin
            mem[32'h124 >> 2] = branch_word(-16'sd4);
            mem[32'h110 >> 2] = branch_word(16'sd3);
        end
    endtask

    // One clock: memory answer, redirect and decoder credits
    task automatic run_cycle(input logic do_rst, input logic do_redir,
                             input logic [31:0] rpc, input int prob, input logic hold);
        @(posedge clk);
        #2;
        rst      = do_rst;
        imem_rsp = '0;
        if (req_q.valid) begin
            imem_rsp.inst[0] = mem[{req_q.pc[9:3], 1'b0}];
            imem_rsp.inst[1] = mem[{req_q.pc[9:3], 1'b1}];
            imem_rsp.fault   = (req_q.pc >= FAULT_LO) && (req_q.pc < FAULT_HI);
        end
        redirect_valid = do_redir;
        redirect_pc    = rpc;
        seed           = lcg_next(seed);
        dec_credit     = 1'b0;
        if (!do_rst && !hold && owed > 0 && ((seed >> 8) % 32'd100) < prob) begin
            dec_credit = 1'b1;
            owed--;
        end
        @(negedge clk);
        req_q = imem_req;
        if (do_rst) begin
            owed = 0;
        end else if (bundle.valid) begin
            owed++;
            got++;
        end
    endtask

    initial begin
        scenario_t sc;
        int        cyc;
        int        sva_fails;
        int        limit;
        rst            = 1'b1;
        imem_rsp       = '0;
        redirect_valid = 1'b0;
        redirect_pc    = '0;
        dec_credit     = 1'b0;
        req_q          = '0;
        seed           = 32'hd76a;
        owed           = 0;
        checked        = 0;
        // kind, credit %, hold cycles, redirect cycle, redirect pc, bundles
        scen[0] = {2'd0, 8'd100, 8'd0, 8'd0, 32'h0000_0000, 8'd12};
        scen[1] = {2'd1, 8'd70, 8'd0, 8'd0, 32'h0000_0000, 8'd16};
        scen[2] = {2'd2, 8'd50, 8'd0, 8'd0, 32'h0000_0000, 8'd16};
        scen[3] = {2'd0, 8'd100, 8'd0, 8'd10, 32'h0000_0200, 8'd14};
        scen[4] = {2'd0, 8'd20, 8'd40, 8'd0, 32'h0000_0000, 8'd12};
        scen[5] = {2'd1, 8'd60, 8'd0, 8'd15, 32'h0000_0130, 8'd18};
        limit = 0;
        for (int s = 0; s < NUM_SCEN; s++) begin
            limit += 20 * scen[s].count;
        end
        limit_cycles = limit + 300;
        for (int s = 0; s < NUM_SCEN; s++) begin
            sc = scen[s];
            load_program(sc.kind);
            repeat (3) run_cycle(1'b1, 1'b0, '0, 0, 1'b1);
            got = 0;
            cyc = 0;
            while (got < sc.count) begin
                run_cycle(1'b0, (sc.redir_cycle != 0) && (cyc == sc.redir_cycle),
                          sc.redir_pc, sc.prob, cyc < sc.hold);
                cyc++;
            end
            checked += got;
        end
        @(posedge clk);
        sva_fails = UUT.u_inst_buffer.u_buffer_sva.fail_count
                  + UUT.u_pc_gen.u_fetch_sva.fail_count;
        $display("Bundles: %0d, checker errors: %0d, assertion failures: %0d",
                 checked, chk_errors, sva_fails);
        if (chk_errors == 0 && sva_fails == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    // Watchdog sized from the table
    initial begin
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk);
        $display("Watchdog expired before all scenarios received their bundles");
        $display("** FAIL **");
        $finish;
    end

endmodule

//--- all.f
+incdir+common
common/fetch_pkg.sv
common/isa_pkg.sv
rtl/pc_gen.sv
rtl/branch_predictor.sv
inst_buffer/fifo_bank.sv
inst_buffer/inst_buffer.sv
rtl/frontend_top.sv
dv/frontend_sva.sv
dv/frontend_checker.sv
dv/frontend_tb.sv

//--- Bender.yml
package:
  name: frontend

export_include_dirs:
  - common

sources:
  - common/fetch_pkg.sv
  - common/isa_pkg.sv
  - rtl/pc_gen.sv
  - rtl/branch_predictor.sv
  - inst_buffer/fifo_bank.sv
  - inst_buffer/inst_buffer.sv
  - rtl/frontend_top.sv
  - target: test
    files:
      - dv/frontend_sva.sv
      - dv/frontend_checker.sv
      - dv/frontend_tb.sv
